//--- hdl/tile_pkg.sv
// Shared constants and types for the single-issue RV32I execution slice
// Only ADD, SUB, AND, OR, XOR, ADDI, BEQ and BNE are decoded, all else is illegal

package tile_pkg;

  // --------------------------------------------------
  // Widths and pipeline depth
  // --------------------------------------------------
  localparam int XLEN      = 32;
  localparam int REG_NUM   = 32;
  localparam int REG_IDX_W = 5;

  // Cycles from dispatch strobe to done report
  localparam int LATENCY   = 3;

  // --------------------------------------------------
  // Instruction encodings
  // --------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;
  localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
  localparam logic [2:0] FUNCT3_BNE     = 3'b001;

  // SUB differs from ADD by this funct7, the others need funct7 zero
  localparam logic [6:0] FUNCT7_SUB = 7'b0100000;

  // --------------------------------------------------
  // Operations and categories
  // --------------------------------------------------
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_BEQ,
    OP_BNE,
    OP_ILLEGAL
  } op_e;

  typedef enum logic [1:0] {
    CAT_ALU,
    CAT_BR,
    CAT_NONE
  } cat_e;

  // --------------------------------------------------
  // Stage payloads
  // --------------------------------------------------
  // Source indices ride along so execute can bypass its own result
  typedef struct packed {
    logic                 valid;
    cat_e                 cat;
    op_e                  op;
    logic [REG_IDX_W-1:0] rd;
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      pc;
    logic                 illegal;
  } dec_inst_t;

  typedef struct packed {
    logic                 valid;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      data;
  } phy_wr_t;

  typedef struct packed {
    logic                 valid;
    logic [REG_IDX_W-1:0] rd;
    logic [XLEN-1:0]      data;
    logic                 br_taken;
    logic [XLEN-1:0]      br_target;
    logic                 illegal;
  } done_rpt_t;

endpackage

//--- hdl/tile_regfile.sv
// Integer register file with two asynchronous read ports and one write port
// x0 reads as zero and ignores writes

`timescale 1ns/10ps

module tile_regfile (
  input  logic                           i_clk,
  input  logic                           i_rst_n,

  input  logic [tile_pkg::REG_IDX_W-1:0] i_rs1_idx,
  input  logic [tile_pkg::REG_IDX_W-1:0] i_rs2_idx,
  output logic [tile_pkg::XLEN-1:0]      o_rs1_data,
  output logic [tile_pkg::XLEN-1:0]      o_rs2_data,

  input  tile_pkg::phy_wr_t              i_wr
);

  // Entry 0 has no storage
  logic [tile_pkg::XLEN-1:0] r_regs [1:tile_pkg::REG_NUM-1];

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < tile_pkg::REG_NUM; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_wr.valid && (i_wr.rd != '0)) begin
      r_regs[i_wr.rd] <= i_wr.data;
    end
  end

  // --------------------------------------------------
  // Read ports
  // --------------------------------------------------
  always_comb begin
    if (i_rs1_idx == '0) begin
      o_rs1_data = '0;
    end else begin
      o_rs1_data = r_regs[i_rs1_idx];
    end
  end

  always_comb begin
    if (i_rs2_idx == '0) begin
      o_rs2_data = '0;
    end else begin
      o_rs2_data = r_regs[i_rs2_idx];
    end
  end

endmodule

//--- hdl/tile_decode.sv
// Decode stage that accepts one instruction per strobe with no back-pressure
// Operands come from the register file or the execute-stage write bus

`timescale 1ns/10ps

module tile_decode (
  input  logic                           i_clk,
  input  logic                           i_rst_n,

  input  logic                           i_inst_valid,
  input  logic [tile_pkg::XLEN-1:0]      i_inst,
  input  logic [tile_pkg::XLEN-1:0]      i_pc,

  output logic [tile_pkg::REG_IDX_W-1:0] o_rs1_idx,
  output logic [tile_pkg::REG_IDX_W-1:0] o_rs2_idx,
  input  logic [tile_pkg::XLEN-1:0]      i_rs1_data,
  input  logic [tile_pkg::XLEN-1:0]      i_rs2_data,

  input  tile_pkg::phy_wr_t              i_early_wr,
  output tile_pkg::dec_inst_t            o_dec
);

  logic [6:0]          w_opcode;
  logic [2:0]          w_funct3;
  logic [6:0]          w_funct7;
  tile_pkg::dec_inst_t w_dec;

  assign w_opcode  = i_inst[6:0];
  assign w_funct3  = i_inst[14:12];
  assign w_funct7  = i_inst[31:25];
  assign o_rs1_idx = i_inst[19:15];
  assign o_rs2_idx = i_inst[24:20];

  // --------------------------------------------------
  // Opcode and immediate decode
  // --------------------------------------------------
  always_comb begin
    w_dec.op  = tile_pkg::OP_ILLEGAL;
    w_dec.imm = '0;
    case (w_opcode)
      tile_pkg::OPC_OP: begin
        if (w_funct7 == '0) begin
          case (w_funct3)
            tile_pkg::FUNCT3_ADD_SUB: w_dec.op = tile_pkg::OP_ADD;
            tile_pkg::FUNCT3_XOR:     w_dec.op = tile_pkg::OP_XOR;
            tile_pkg::FUNCT3_OR:      w_dec.op = tile_pkg::OP_OR;
            tile_pkg::FUNCT3_AND:     w_dec.op = tile_pkg::OP_AND;
            default:                  w_dec.op = tile_pkg::OP_ILLEGAL;
          endcase
        end else if ((w_funct7 == tile_pkg::FUNCT7_SUB) &&
                     (w_funct3 == tile_pkg::FUNCT3_ADD_SUB)) begin
          w_dec.op = tile_pkg::OP_SUB;
        end
      end
      tile_pkg::OPC_OP_IMM: begin
        // Only ADDI among the immediate ops
        if (w_funct3 == tile_pkg::FUNCT3_ADD_SUB) begin
          w_dec.op  = tile_pkg::OP_ADDI;
          w_dec.imm = {{20{i_inst[31]}}, i_inst[31:20]};
        end
      end
      tile_pkg::OPC_BRANCH: begin
        if (w_funct3 == tile_pkg::FUNCT3_BEQ) begin
          w_dec.op = tile_pkg::OP_BEQ;
        end else if (w_funct3 == tile_pkg::FUNCT3_BNE) begin
          w_dec.op = tile_pkg::OP_BNE;
        end
        w_dec.imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                     i_inst[11:8], 1'b0};
      end
      default: w_dec.op = tile_pkg::OP_ILLEGAL;
    endcase

    case (w_dec.op)
      tile_pkg::OP_BEQ, tile_pkg::OP_BNE: w_dec.cat = tile_pkg::CAT_BR;
      tile_pkg::OP_ILLEGAL:               w_dec.cat = tile_pkg::CAT_NONE;
      default:                            w_dec.cat = tile_pkg::CAT_ALU;
    endcase

    w_dec.valid   = i_inst_valid;
    w_dec.illegal = (w_dec.op == tile_pkg::OP_ILLEGAL);
    w_dec.rd      = i_inst[11:7];
    w_dec.rs1_idx = o_rs1_idx;
    w_dec.rs2_idx = o_rs2_idx;
    w_dec.pc      = i_pc;

    // Early write valid already implies a nonzero rd
    if (i_early_wr.valid && (i_early_wr.rd == o_rs1_idx)) begin
      w_dec.rs1_data = i_early_wr.data;
    end else begin
      w_dec.rs1_data = i_rs1_data;
    end
    if (i_early_wr.valid && (i_early_wr.rd == o_rs2_idx)) begin
      w_dec.rs2_data = i_early_wr.data;
    end else begin
      w_dec.rs2_data = i_rs2_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_dec.valid <= 1'b0;
    end else begin
      o_dec <= w_dec;
    end
  end

  a_illegal_no_cat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_dec.valid && o_dec.illegal) |-> (o_dec.cat == tile_pkg::CAT_NONE));

endmodule

//--- hdl/tile_execute.sv
// Execute stage for ALU ops and BEQ/BNE at one instruction per cycle
// Bypasses its own registered write to the instruction right behind it

`timescale 1ns/10ps

module tile_execute (
  input  logic                i_clk,
  input  logic                i_rst_n,

  input  tile_pkg::dec_inst_t i_dec,

  output tile_pkg::phy_wr_t   o_early_wr,
  output tile_pkg::done_rpt_t o_rpt
);

  logic [tile_pkg::XLEN-1:0] w_op_a;
  logic [tile_pkg::XLEN-1:0] w_op_b;
  logic [tile_pkg::XLEN-1:0] w_alu_res;
  logic                      w_taken;
  tile_pkg::phy_wr_t         w_wr;
  tile_pkg::done_rpt_t       w_rpt;

  // The previous instruction was still in decode when these operands were read
  assign w_op_a = (o_early_wr.valid && (o_early_wr.rd == i_dec.rs1_idx)) ?
                  o_early_wr.data : i_dec.rs1_data;
  assign w_op_b = (o_early_wr.valid && (o_early_wr.rd == i_dec.rs2_idx)) ?
                  o_early_wr.data : i_dec.rs2_data;

  // --------------------------------------------------
  // ALU and branch compare
  // --------------------------------------------------
  always_comb begin
    w_alu_res = '0;
    w_taken   = 1'b0;
    case (i_dec.op)
      tile_pkg::OP_ADD:  w_alu_res = w_op_a + w_op_b;
      tile_pkg::OP_SUB:  w_alu_res = w_op_a - w_op_b;
      tile_pkg::OP_AND:  w_alu_res = w_op_a & w_op_b;
      tile_pkg::OP_OR:   w_alu_res = w_op_a | w_op_b;
      tile_pkg::OP_XOR:  w_alu_res = w_op_a ^ w_op_b;
      tile_pkg::OP_ADDI: w_alu_res = w_op_a + i_dec.imm;
      tile_pkg::OP_BEQ:  w_taken   = (w_op_a == w_op_b);
      tile_pkg::OP_BNE:  w_taken   = (w_op_a != w_op_b);
      default:           w_alu_res = '0;
    endcase
  end

  always_comb begin
    w_wr.valid = i_dec.valid && !i_dec.illegal &&
                 (i_dec.cat == tile_pkg::CAT_ALU) && (i_dec.rd != '0);
    w_wr.rd    = i_dec.rd;
    w_wr.data  = w_alu_res;

    // Non-ALU reports carry rd and data as zero
    w_rpt.valid   = i_dec.valid;
    w_rpt.illegal = i_dec.illegal;
    if (i_dec.cat == tile_pkg::CAT_ALU) begin
      w_rpt.rd   = i_dec.rd;
      w_rpt.data = w_alu_res;
    end else begin
      w_rpt.rd   = '0;
      w_rpt.data = '0;
    end
    if (i_dec.cat == tile_pkg::CAT_BR) begin
      w_rpt.br_taken  = w_taken;
      w_rpt.br_target = i_dec.pc + i_dec.imm;
    end else begin
      w_rpt.br_taken  = 1'b0;
      w_rpt.br_target = '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_early_wr.valid <= 1'b0;
      o_rpt.valid      <= 1'b0;
    end else begin
      o_early_wr <= w_wr;
      o_rpt      <= w_rpt;
    end
  end

  a_wr_has_rpt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_early_wr.valid |-> (o_rpt.valid && !o_rpt.illegal));

endmodule

//--- hdl/tile_result.sv
// Completion stage with one done report per instruction in dispatch order
// The register write goes out combinationally one cycle ahead of the report

`timescale 1ns/10ps

module tile_result (
  input  logic                i_clk,
  input  logic                i_rst_n,

  input  tile_pkg::phy_wr_t   i_early_wr,
  input  tile_pkg::done_rpt_t i_rpt,

  output tile_pkg::phy_wr_t   o_wr,
  output tile_pkg::done_rpt_t o_done
);

  // --------------------------------------------------
  // Register-file write
  // --------------------------------------------------
  // Write only what the matching report calls legal
  always_comb begin
    o_wr.valid = i_early_wr.valid && i_rpt.valid && !i_rpt.illegal;
    o_wr.rd    = i_early_wr.rd;
    o_wr.data  = i_early_wr.data;
  end

  // --------------------------------------------------
  // Done report
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_done.valid <= 1'b0;
    end else begin
      o_done <= i_rpt;
    end
  end

  // Every outgoing pulse needs its own report one cycle earlier
  a_done_from_rpt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_done.valid |-> $past(i_rpt.valid));

endmodule

//--- hdl/tile_top.sv
// Execution slice top with decode, execute, result and register file
// Fixed latency of three cycles with no flush and no back-pressure

`timescale 1ns/10ps

module tile_top (
  input  logic                      i_clk,
  input  logic                      i_rst_n,

  input  logic                      i_inst_valid,
  input  logic [tile_pkg::XLEN-1:0] i_inst,
  input  logic [tile_pkg::XLEN-1:0] i_pc,

  output tile_pkg::done_rpt_t       o_done
);

  logic [tile_pkg::REG_IDX_W-1:0] w_rs1_idx;
  logic [tile_pkg::REG_IDX_W-1:0] w_rs2_idx;
  logic [tile_pkg::XLEN-1:0]      w_rs1_data;
  logic [tile_pkg::XLEN-1:0]      w_rs2_data;
  tile_pkg::dec_inst_t            w_dec;
  tile_pkg::phy_wr_t              w_early_wr;
  tile_pkg::done_rpt_t            w_exe_rpt;
  tile_pkg::phy_wr_t              w_rf_wr;

  tile_decode u_decode (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_pc         (i_pc),
    .o_rs1_idx    (w_rs1_idx),
    .o_rs2_idx    (w_rs2_idx),
    .i_rs1_data   (w_rs1_data),
    .i_rs2_data   (w_rs2_data),
    .i_early_wr   (w_early_wr),
    .o_dec        (w_dec)
  );

  tile_execute u_execute (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_dec      (w_dec),
    .o_early_wr (w_early_wr),
    .o_rpt      (w_exe_rpt)
  );

  tile_result u_result (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_early_wr (w_early_wr),
    .i_rpt      (w_exe_rpt),
    .o_wr       (w_rf_wr),
    .o_done     (o_done)
  );

  tile_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_rs1_idx  (w_rs1_idx),
    .i_rs2_idx  (w_rs2_idx),
    .o_rs1_data (w_rs1_data),
    .o_rs2_data (w_rs2_data),
    .i_wr       (w_rf_wr)
  );

endmodule

//--- dv/tile_tb.sv
// Random instruction test of the slice against an in-order register model
// Inputs change and done reports are checked on the falling edge

`timescale 1ns/10ps

module tile_tb;

  localparam int NUM_RAND      = 400;
  localparam int DRAIN_TIMEOUT = 20;

  // Instruction kinds for the stimulus
  localparam int K_ADD     = 0;
  localparam int K_SUB     = 1;
  localparam int K_AND     = 2;
  localparam int K_OR      = 3;
  localparam int K_XOR     = 4;
  localparam int K_ADDI    = 5;
  localparam int K_BEQ     = 6;
  localparam int K_BNE     = 7;
  localparam int K_ILLEGAL = 8;

  logic                      clk;
  logic                      rst_n;
  logic                      inst_valid;
  logic [tile_pkg::XLEN-1:0] inst;
  logic [tile_pkg::XLEN-1:0] pc;
  tile_pkg::done_rpt_t       done;

  logic [31:0]               rng_state;
  logic [tile_pkg::XLEN-1:0] ref_regs [tile_pkg::REG_NUM];
  tile_pkg::done_rpt_t       exp_q [$];
  int                        due_q [$];
  int                        cycle_cnt;
  int                        err_cnt;
  int                        rpt_cnt;

  tile_top u_tile_top (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_inst_valid (inst_valid),
    .i_inst       (inst),
    .i_pc         (pc),
    .o_done       (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------
  // Random numbers and instruction encoders
  // --------------------------------------------------
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, tile_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1);
    return {imm, rs1, f3, rd, tile_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3,
                                       input logic [4:0] rs1, input logic [4:0] rs2);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], tile_pkg::OPC_BRANCH};
  endfunction

  // --------------------------------------------------
  // Checking of done reports
  // --------------------------------------------------
  task automatic check_done();
    tile_pkg::done_rpt_t exp;
    int                  due;
    if (!done.valid) begin
      if ((due_q.size() != 0) && (due_q[0] <= cycle_cnt)) begin
        $display("Done report missing for the instruction due at cycle %0d", due_q[0]);
        err_cnt++;
        exp = exp_q.pop_front();
        due = due_q.pop_front();
      end
    end else if (exp_q.size() == 0) begin
      $display("Done report at cycle %0d with no instruction in flight", cycle_cnt);
      err_cnt++;
    end else begin
      exp = exp_q.pop_front();
      due = due_q.pop_front();
      rpt_cnt++;
      if (due != cycle_cnt) begin
        $display("** Error: o_done.valid cycle exp %h got %h", due, cycle_cnt);
        err_cnt++;
      end
      if (done.rd !== exp.rd) begin
        $display("** Error: o_done.rd exp %h got %h", exp.rd, done.rd);
        err_cnt++;
      end
      if (done.data !== exp.data) begin
        $display("** Error: o_done.data exp %h got %h", exp.data, done.data);
        err_cnt++;
      end
      if (done.br_taken !== exp.br_taken) begin
        $display("** Error: o_done.br_taken exp %h got %h", exp.br_taken, done.br_taken);
        err_cnt++;
      end
      if (done.br_target !== exp.br_target) begin
        $display("** Error: o_done.br_target exp %h got %h", exp.br_target, done.br_target);
        err_cnt++;
      end
      if (done.illegal !== exp.illegal) begin
        $display("** Error: o_done.illegal exp %h got %h", exp.illegal, done.illegal);
        err_cnt++;
      end
    end
  endtask

  // Check outputs on each falling edge before driving the next inputs
  task automatic step(input logic v, input logic [31:0] word, input logic [31:0] pcv,
                      input tile_pkg::done_rpt_t exp);
    @(negedge clk);
    cycle_cnt++;
    check_done();
    inst_valid = v;
    inst       = word;
    pc         = pcv;
    if (v) begin
      exp_q.push_back(exp);
      due_q.push_back(cycle_cnt + tile_pkg::LATENCY);
    end
  endtask

  // Garbage on the bus while the strobe is low
  task automatic idle_cycle();
    step(1'b0, next_rand(), next_rand(), '0);
  endtask

  // --------------------------------------------------
  // Reference model executed at dispatch
  // --------------------------------------------------
  task automatic send(input int kind, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [4:0] rs2, input logic [12:0] imm,
                      input logic [2:0] bad_sel, input logic [31:0] pcv);
    logic [31:0]         word;
    logic [31:0]         a;
    logic [31:0]         b;
    logic [31:0]         res;
    tile_pkg::done_rpt_t exp;
    a         = ref_regs[rs1];
    b         = ref_regs[rs2];
    res       = '0;
    exp       = '0;
    exp.valid = 1'b1;
    // Function codes straight from the RV32I tables
    case (kind)
      K_ADD: begin
        word = enc_r(7'h00, 3'b000, rd, rs1, rs2);
        res  = a + b;
      end
      K_SUB: begin
        word = enc_r(7'h20, 3'b000, rd, rs1, rs2);
        res  = a - b;
      end
      K_AND: begin
        word = enc_r(7'h00, 3'b111, rd, rs1, rs2);
        res  = a & b;
      end
      K_OR: begin
        word = enc_r(7'h00, 3'b110, rd, rs1, rs2);
        res  = a | b;
      end
      K_XOR: begin
        word = enc_r(7'h00, 3'b100, rd, rs1, rs2);
        res  = a ^ b;
      end
      K_ADDI: begin
        word = enc_i(imm[11:0], 3'b000, rd, rs1);
        res  = a + {{20{imm[11]}}, imm[11:0]};
      end
      K_BEQ, K_BNE: begin
        word = enc_b(imm, (kind == K_BEQ) ? 3'b000 : 3'b001, rs1, rs2);
        exp.br_taken  = (kind == K_BEQ) ? (a == b) : (a != b);
        exp.br_target = pcv + {{19{imm[12]}}, imm[12:1], 1'b0};
      end
      default: begin
        case (bad_sel)
          3'd0:    word = enc_r(7'h00, 3'b001, rd, rs1, rs2);
          3'd1:    word = enc_r(7'h20, 3'b100, rd, rs1, rs2);
          3'd2:    word = enc_i(imm[11:0], 3'b010, rd, rs1);
          3'd3:    word = enc_b(imm, 3'b100, rs1, rs2);
          3'd4:    word = enc_r(7'h01, 3'b000, rd, rs1, rs2);
          default: word = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
        endcase
        exp.illegal = 1'b1;
      end
    endcase
    if (kind <= K_ADDI) begin
      exp.rd   = rd;
      exp.data = res;
      if (rd != 5'd0) begin
        ref_regs[rd] = res;
      end
    end
    step(1'b1, word, pcv, exp);
  endtask

  // Registers limited to x0..x7 so dependencies are frequent
  task automatic issue_random();
    logic [31:0] r;
    logic [31:0] pcv;
    int          kind;
    r = next_rand();
    case (r[3:0])
      4'd0, 4'd1:       kind = K_ADD;
      4'd2, 4'd14:      kind = K_SUB;
      4'd3:             kind = K_AND;
      4'd4:             kind = K_OR;
      4'd5:             kind = K_XOR;
      4'd6, 4'd7, 4'd8: kind = K_ADDI;
      4'd9, 4'd10:      kind = K_BEQ;
      4'd11, 4'd12:     kind = K_BNE;
      4'd13:            kind = K_ILLEGAL;
      default:          kind = K_ADDI;
    endcase
    pcv = next_rand() & 32'hffff_fffc;
    send(kind, {2'b00, r[6:4]}, {2'b00, r[9:7]}, {2'b00, r[12:10]}, r[25:13],
         r[28:26], pcv);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] r;
    int          gap;
    rng_state  = 32'hf9ef_9ea4;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    cycle_cnt  = 0;
    err_cnt    = 0;
    rpt_cnt    = 0;
    for (int i = 0; i < tile_pkg::REG_NUM; i++) begin
      ref_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Quiet output after reset
    for (int i = 0; i < 6; i++) begin
      idle_cycle();
    end

    // ADD x0, xi, xi reads every register back as zero
    for (int i = 1; i < tile_pkg::REG_NUM; i++) begin
      send(K_ADD, 5'd0, i[4:0], i[4:0], '0, '0, 32'h0000_0100);
    end

    // Mostly back-to-back with occasional short gaps
    for (int n = 0; n < NUM_RAND; n++) begin
      r = next_rand();
      if (r[1:0] == 2'b00) begin
        gap = r[3:2] + 1;
        for (int g = 0; g < gap; g++) begin
          idle_cycle();
        end
      end
      issue_random();
    end

    for (int w = 0; (w < DRAIN_TIMEOUT) && (exp_q.size() != 0); w++) begin
      idle_cycle();
    end
    if (exp_q.size() != 0) begin
      $display("Timed out waiting for %0d outstanding done reports", exp_q.size());
      err_cnt++;
    end
    // Catch stray reports after the drain
    for (int i = 0; i < 4; i++) begin
      idle_cycle();
    end

    $display("Done reports checked: %0d, errors: %0d", rpt_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- sim.f
hdl/tile_pkg.sv
hdl/tile_regfile.sv
hdl/tile_decode.sv
hdl/tile_execute.sv
hdl/tile_result.sv
hdl/tile_top.sv
dv/tile_tb.sv

//--- Makefile
# Verilator build and run for the execution slice testbench

VERILATOR ?= verilator
TOP       ?= tile_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  OBJ_DIR=$(OBJ_DIR) VFLAGS=$(VFLAGS)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
